// File: rtl/rv_pkg.sv
`default_nettype none

package rv_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Core sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int XLEN = 32;
    localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_AW = $clog2(DMEM_WORDS);      // Word index width.
    localparam logic [4:0] EXIT_REG = 5'd10;          // a0 carries the exit code.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    // ALU operand pairs, same order as the four-way select.
    typedef enum logic [1:0] {
        OPSEL_ZERO_IMM = 2'b00,
        OPSEL_PC_IMM   = 2'b01,
        OPSEL_RS1_RS2  = 2'b10,
        OPSEL_RS1_IMM  = 2'b11
    } opsel_e;

    typedef enum logic [1:0] {
        NPC_SEQ, NPC_BRANCH, NPC_JAL, NPC_JALR
    } npc_e;

    typedef enum logic [1:0] {
        MEM_NONE, MEM_BYTE, MEM_HALF, MEM_WORD
    } mem_size_e;

endpackage

`default_nettype wire

// File: rtl/rv_alu.sv
`default_nettype none

module rv_alu import rv_pkg::*; (
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  alu_op_e         op,
    output logic [XLEN-1:0] result
);
    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];                       // RV32 shift range.
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $unsigned($signed(a) >>> shamt); // Keeps the sign bit.
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/rv_decoder.sv
`default_nettype none

module rv_decoder import rv_pkg::*; (
    input  logic [XLEN-1:0] instr,
    output logic [4:0]      rs1_addr,
    output logic [4:0]      rs2_addr,
    output logic [4:0]      rd_addr,
    output logic [XLEN-1:0] imm,
    output alu_op_e         alu_op,
    output opsel_e          opsel,
    output npc_e            npc_sel,
    output logic [2:0]      br_funct,
    output mem_size_e       mem_size,
    output logic            mem_write,
    output logic            mem_unsigned,
    output logic            rd_we,
    output logic            is_ebreak
);
    opcode_e         opcode;
    logic [2:0]      funct3;
    logic            alt;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    alu_op_e         arith_op;
    mem_size_e       ls_size;

    assign opcode   = opcode_e'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign alt      = instr[30];                       // Selects sub and sra.
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];
    assign rd_addr  = instr[11:7];
    assign br_funct = funct3;

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    assign ls_size = (funct3[1:0] == 2'b00) ? MEM_BYTE :
                     (funct3[1:0] == 2'b01) ? MEM_HALF : MEM_WORD;

    always_comb begin
        case (funct3)
            3'b000:  arith_op = (opcode == OPC_OP && alt) ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        imm          = '0;                             // Bubble unless matched.
        alu_op       = ALU_ADD;
        opsel        = OPSEL_RS1_IMM;
        npc_sel      = NPC_SEQ;
        mem_size     = MEM_NONE;
        mem_write    = 1'b0;
        mem_unsigned = 1'b0;
        rd_we        = 1'b0;
        is_ebreak    = 1'b0;
        case (opcode)
            OPC_LUI:    begin imm = imm_u; opsel = OPSEL_ZERO_IMM; rd_we = 1'b1; end
            OPC_AUIPC:  begin imm = imm_u; opsel = OPSEL_PC_IMM; rd_we = 1'b1; end
            OPC_JAL:    begin imm = imm_j; npc_sel = NPC_JAL; rd_we = 1'b1; end
            OPC_JALR:   begin imm = imm_i; npc_sel = NPC_JALR; rd_we = 1'b1; end
            OPC_BRANCH: begin imm = imm_b; opsel = OPSEL_RS1_RS2; npc_sel = NPC_BRANCH; end
            OPC_LOAD: begin
                imm          = imm_i;
                mem_size     = ls_size;
                mem_unsigned = funct3[2];              // lbu and lhu.
                rd_we        = 1'b1;
            end
            OPC_STORE:  begin imm = imm_s; mem_size = ls_size; mem_write = 1'b1; end
            OPC_OP_IMM: begin imm = imm_i; alu_op = arith_op; rd_we = 1'b1; end
            OPC_OP:     begin opsel = OPSEL_RS1_RS2; alu_op = arith_op; rd_we = 1'b1; end
            OPC_SYSTEM: is_ebreak = (instr[31:7] == 25'h0002000); // ecall stays a bubble.
            default:    ;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/rv_exu.sv
`default_nettype none

module rv_exu import rv_pkg::*; (
    input  opsel_e          opsel,
    input  alu_op_e         alu_op,
    input  npc_e            npc_sel,
    input  logic [2:0]      br_funct,
    input  mem_size_e       mem_size,
    input  logic            mem_write,
    input  logic            is_ebreak,
    input  logic            halted,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] rs2_data,
    input  logic [XLEN-1:0] imm,
    input  logic [XLEN-1:0] pc,
    output logic [XLEN-1:0] result,
    output logic [XLEN-1:0] dnpc,
    output logic [XLEN-1:0] mem_addr,
    output logic [XLEN-1:0] mem_wdata,
    output logic            mem_we,
    output logic            ebreak_hit
);
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] npc_a;
    logic [XLEN-1:0] npc_b;
    logic [XLEN-1:0] npc_sum;
    logic [XLEN-1:0] link;
    logic            br_taken;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ALU
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (opsel)
            OPSEL_ZERO_IMM: {op_a, op_b} = {{XLEN{1'b0}}, imm};
            OPSEL_PC_IMM:   {op_a, op_b} = {pc, imm};
            OPSEL_RS1_RS2:  {op_a, op_b} = {rs1_data, rs2_data};
            default:        {op_a, op_b} = {rs1_data, imm};
        endcase
    end

    rv_alu alu_i (
        .a      (op_a),
        .b      (op_b),
        .op     (alu_op),
        .result (alu_res)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // PC update
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (br_funct)
            3'b000:  br_taken = (rs1_data == rs2_data);
            3'b001:  br_taken = (rs1_data != rs2_data);
            3'b100:  br_taken = ($signed(rs1_data) < $signed(rs2_data));
            3'b101:  br_taken = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110:  br_taken = (rs1_data < rs2_data);
            3'b111:  br_taken = (rs1_data >= rs2_data);
            default: br_taken = 1'b0;
        endcase
    end

    always_comb begin
        case (npc_sel)
            NPC_BRANCH: {npc_a, npc_b} = {pc, br_taken ? imm : XLEN'(4)};
            NPC_JAL:    {npc_a, npc_b} = {pc, imm};
            NPC_JALR:   {npc_a, npc_b} = {rs1_data, imm};
            default:    {npc_a, npc_b} = {pc, XLEN'(4)};
        endcase
    end

    assign npc_sum = npc_a + npc_b;                    // Own adder, not the ALU.
    assign dnpc    = (npc_sel == NPC_JALR) ? {npc_sum[XLEN-1:1], 1'b0} : npc_sum;
    assign link    = pc + XLEN'(4);
    assign result  = (npc_sel == NPC_JAL || npc_sel == NPC_JALR) ? link : alu_res;

    // Memory request and system.
    assign mem_addr   = alu_res;
    assign mem_wdata  = rs2_data;
    assign mem_we     = mem_write && (mem_size != MEM_NONE) && !halted;
    assign ebreak_hit = is_ebreak && !halted;

endmodule

`default_nettype wire

// File: rtl/rv_gpr.sv
`default_nettype none

module rv_gpr import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            we,
    input  logic [4:0]      rs1_addr,
    input  logic [4:0]      rs2_addr,
    input  logic [4:0]      rd_addr,
    input  logic [XLEN-1:0] rd_data,
    input  logic [4:0]      exit_addr,
    output logic [XLEN-1:0] rs1_data,
    output logic [XLEN-1:0] rs2_data,
    output logic [XLEN-1:0] exit_data
);
    logic [XLEN-1:0] regs [1:31];                      // x0 has no storage.

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd_addr != 5'd0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // Reads see the value before this cycle's write.
    assign rs1_data  = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data  = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];
    assign exit_data = (exit_addr == 5'd0) ? '0 : regs[exit_addr];

endmodule

`default_nettype wire

// File: rtl/rv_lsu.sv
`default_nettype none

module rv_lsu import rv_pkg::*; (
    input  logic            clk,
    input  logic            we,
    input  logic [XLEN-1:0] addr,
    input  logic [XLEN-1:0] wdata,
    input  mem_size_e       size,
    input  logic            unsigned_ld,
    output logic [XLEN-1:0] rdata
);
    logic [XLEN-1:0]    mem [DMEM_WORDS];
    logic [DMEM_AW-1:0] word_idx;
    logic [1:0]         lane;
    logic [3:0]         base_mask;
    logic [3:0]         wmask;
    logic [XLEN-1:0]    wdata_sh;
    logic [XLEN-1:0]    rword;
    logic [XLEN-1:0]    rword_sh;
    logic               sext;

    assign word_idx = addr[DMEM_AW+1:2];               // Wraps at the memory size.
    assign lane     = addr[1:0];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Store path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (size)
            MEM_BYTE: base_mask = 4'b0001;
            MEM_HALF: base_mask = 4'b0011;
            MEM_WORD: base_mask = 4'b1111;
            default:  base_mask = 4'b0000;
        endcase
    end

    assign wmask    = base_mask << lane;
    assign wdata_sh = wdata << {lane, 3'b000};         // Data moved into its lanes.

    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < 4; b++) begin
                if (wmask[b]) begin
                    mem[word_idx][8*b +: 8] <= wdata_sh[8*b +: 8];
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Load path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign rword    = mem[word_idx];
    assign rword_sh = rword >> {lane, 3'b000};         // Addressed byte to bit 0.
    assign sext     = !unsigned_ld;

    always_comb begin
        case (size)
            MEM_BYTE: rdata = {{24{sext & rword_sh[7]}}, rword_sh[7:0]};
            MEM_HALF: rdata = {{16{sext & rword_sh[15]}}, rword_sh[15:0]};
            default:  rdata = rword;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/rv_core.sv
`default_nettype none

module rv_core import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic [XLEN-1:0] instr,
    output logic [XLEN-1:0] pc,
    output logic            wb_en,
    output logic [4:0]      wb_addr,
    output logic [XLEN-1:0] wb_data,
    output logic            halt,
    output logic [XLEN-1:0] halt_code
);
    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [4:0]      rd_addr;
    logic [XLEN-1:0] imm;
    alu_op_e         alu_op;
    opsel_e          opsel;
    npc_e            npc_sel;
    logic [2:0]      br_funct;
    mem_size_e       mem_size;
    logic            mem_write;
    logic            mem_unsigned;
    logic            rd_we;
    logic            is_ebreak;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] exit_data;
    logic [XLEN-1:0] exu_result;
    logic [XLEN-1:0] dnpc;
    logic [XLEN-1:0] mem_addr;
    logic [XLEN-1:0] mem_wdata;
    logic            mem_we;
    logic            ebreak_hit;
    logic [XLEN-1:0] ld_data;
    logic            is_load;

    rv_decoder decoder_i (
        .instr        (instr),        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),     .rd_addr      (rd_addr),
        .imm          (imm),          .alu_op       (alu_op),
        .opsel        (opsel),        .npc_sel      (npc_sel),
        .br_funct     (br_funct),     .mem_size     (mem_size),
        .mem_write    (mem_write),    .mem_unsigned (mem_unsigned),
        .rd_we        (rd_we),        .is_ebreak    (is_ebreak)
    );

    rv_gpr gpr_i (
        .clk       (clk),       .rst       (rst),
        .we        (wb_en),     .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),  .rd_addr   (rd_addr),
        .rd_data   (wb_data),   .exit_addr (EXIT_REG),
        .rs1_data  (rs1_data),  .rs2_data  (rs2_data),
        .exit_data (exit_data)
    );

    rv_exu exu_i (
        .opsel     (opsel),      .alu_op     (alu_op),
        .npc_sel   (npc_sel),    .br_funct   (br_funct),
        .mem_size  (mem_size),   .mem_write  (mem_write),
        .is_ebreak (is_ebreak),  .halted     (halt),
        .rs1_data  (rs1_data),   .rs2_data   (rs2_data),
        .imm       (imm),        .pc         (pc),
        .result    (exu_result), .dnpc       (dnpc),
        .mem_addr  (mem_addr),   .mem_wdata  (mem_wdata),
        .mem_we    (mem_we),     .ebreak_hit (ebreak_hit)
    );

    rv_lsu lsu_i (
        .clk         (clk),             .we    (mem_we && !rst),
        .addr        (mem_addr),        .wdata (mem_wdata),
        .size        (mem_size),        .rdata (ld_data),
        .unsigned_ld (mem_unsigned)
    );

    // Write-back and retire trace.
    assign is_load = (mem_size != MEM_NONE) && !mem_write;
    assign wb_data = is_load ? ld_data : exu_result;
    assign wb_addr = rd_addr;
    assign wb_en   = rd_we && (rd_addr != 5'd0) && !rst && !halt;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= RESET_PC;
            halt      <= 1'b0;
            halt_code <= '0;
        end else if (ebreak_hit) begin
            halt      <= 1'b1;                         // Sticky until reset.
            halt_code <= exit_data;                    // PC stays on the ebreak.
        end else if (!halt) begin
            pc        <= dnpc;
        end
    end

endmodule

`default_nettype wire

// File: tb/rv_core_checker.sv
`default_nettype none

module rv_core_checker import rv_pkg::*; (
    input logic            clk,
    input logic            rst,
    input logic [XLEN-1:0] instr,
    input logic [XLEN-1:0] pc,
    input logic            halt,
    input logic [XLEN-1:0] halt_code,
    input logic            wb_en,
    input logic [4:0]      wb_addr
);
    timeunit 1ns;
    timeprecision 100ps;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Core invariants
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else $error("pc %h is not word aligned", pc);

    // Only reset may clear halt, and the exit code stays frozen.
    halt_sticky: assert property (@(posedge clk) disable iff (rst)
        halt |=> halt && $stable(halt_code))
        else $error("halt or halt_code changed while reset was low");

    // Writes come only from register-writing opcodes.
    no_x0_write: assert property (@(posedge clk) disable iff (rst)
        wb_en |-> (wb_addr != 5'd0) && (instr[6:0] inside {OPC_LUI, OPC_AUIPC,
            OPC_JAL, OPC_JALR, OPC_LOAD, OPC_OP_IMM, OPC_OP}))
        else $error("wb_en raised for x0 or for an instruction without a result");

endmodule

`default_nettype wire

// File: tb/rv_core_tb.sv
`default_nettype none

module rv_core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
        logic        en;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        halted;
    } row_t;

    logic        clk = 1'b0;
    logic        rst;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        wb_en;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;
    logic        halt;
    logic [31:0] halt_code;

    row_t        rows[$];
    int          row_count = 0;
    int          errors = 0;
    logic [31:0] last_a0 = '0;                         // Expected halt code.

    rv_core dut_i (
        .clk       (clk),
        .rst       (rst),
        .instr     (instr),
        .pc        (pc),
        .wb_en     (wb_en),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data),
        .halt      (halt),
        .halt_code (halt_code)
    );

    bind rv_core rv_core_checker checker_i (
        .clk       (clk),
        .rst       (rst),
        .instr     (instr),
        .pc        (pc),
        .halt      (halt),
        .halt_code (halt_code),
        .wb_en     (wb_en),
        .wb_addr   (wb_addr)
    );

    always #50 clk = ~clk;                             // 100 ns period.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // RV32I instruction formats
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] r_format(input int f7, input int f3, input int rd,
                                             input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] i_format(input int opc, input int f3, input int rd,
                                             input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic logic [31:0] s_format(input int f3, input int rs1, input int rs2,
                                             input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_format(input int f3, input int rs1, input int rs2,
                                             input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] u_format(input int opc, input int rd, input int imm);
        return {imm[19:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic logic [31:0] j_format(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    task automatic add_row(input logic [31:0] code, input logic [31:0] pc_offset,
                           input int en, input int rd, input logic [31:0] data,
                           input int halted);
        row_t r;
        r.instr  = code;
        r.pc     = 32'h8000_0000 + pc_offset;          // Core boot address.
        r.en     = en[0];
        r.rd     = rd[4:0];
        r.data   = data;
        r.halted = halted[0];
        rows.push_back(r);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("Fail at time %0d ns: %s expected %h, got %h",
                     $time, name, expected, actual);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Program table
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic load_program();
        add_row(u_format('h37, 1, 'h12345), 'h00, 1, 1, 'h1234_5000, 0);      // lui
        add_row(i_format('h13, 0, 1, 1, 'h678), 'h04, 1, 1, 'h1234_5678, 0);  // addi
        add_row(i_format('h13, 0, 2, 0, -5), 'h08, 1, 2, 'hFFFF_FFFB, 0);
        add_row(r_format(0, 0, 3, 1, 2), 'h0C, 1, 3, 'h1234_5673, 0);          // add
        add_row(r_format('h20, 0, 4, 1, 2), 'h10, 1, 4, 'h1234_567D, 0);       // sub
        add_row(i_format('h13, 0, 5, 0, 4), 'h14, 1, 5, 'h0000_0004, 0);
        add_row(u_format('h37, 7, 'h80000), 'h18, 1, 7, 'h8000_0000, 0);
        add_row(r_format('h20, 5, 6, 7, 5), 'h1C, 1, 6, 'hF800_0000, 0);       // sra
        add_row(r_format(0, 5, 8, 7, 5), 'h20, 1, 8, 'h0800_0000, 0);          // srl
        add_row(r_format(0, 2, 9, 2, 5), 'h24, 1, 9, 'h0000_0001, 0);          // slt
        add_row(r_format(0, 3, 10, 2, 5), 'h28, 1, 10, 'h0000_0000, 0);        // sltu
        add_row(r_format(0, 1, 11, 1, 5), 'h2C, 1, 11, 'h2345_6780, 0);        // sll
        add_row(r_format(0, 4, 12, 1, 2), 'h30, 1, 12, 'hEDCB_A983, 0);        // xor
        add_row(r_format(0, 6, 13, 1, 5), 'h34, 1, 13, 'h1234_567C, 0);        // or
        add_row(i_format('h13, 7, 14, 1, 'hF0), 'h38, 1, 14, 'h0000_0070, 0);  // andi
        add_row(i_format('h13, 0, 0, 1, 1), 'h3C, 0, 0, 'h0, 0);               // x0 dropped.
        add_row(r_format(0, 0, 15, 0, 0), 'h40, 1, 15, 'h0000_0000, 0);
        add_row(u_format('h17, 16, 1), 'h44, 1, 16, 'h8000_1044, 0);           // auipc
        add_row(j_format(17, 16), 'h48, 1, 17, 'h8000_004C, 0);                // jal
        add_row(u_format('h17, 18, 0), 'h58, 1, 18, 'h8000_0058, 0);
        add_row(i_format('h67, 0, 19, 18, 25), 'h5C, 1, 19, 'h8000_0060, 0);   // jalr
        // Each branch condition taken, then not taken.
        add_row(b_format(0, 5, 5, 8), 'h70, 0, 0, 'h0, 0);
        add_row(b_format(1, 5, 5, 8), 'h78, 0, 0, 'h0, 0);
        add_row(b_format(1, 1, 5, 8), 'h7C, 0, 0, 'h0, 0);
        add_row(b_format(0, 1, 5, 8), 'h84, 0, 0, 'h0, 0);
        add_row(b_format(4, 2, 5, 8), 'h88, 0, 0, 'h0, 0);
        add_row(b_format(4, 5, 2, 8), 'h90, 0, 0, 'h0, 0);
        add_row(b_format(5, 5, 2, 8), 'h94, 0, 0, 'h0, 0);
        add_row(b_format(5, 2, 5, 8), 'h9C, 0, 0, 'h0, 0);
        add_row(b_format(6, 5, 2, 8), 'hA0, 0, 0, 'h0, 0);
        add_row(b_format(6, 2, 5, 8), 'hA8, 0, 0, 'h0, 0);
        add_row(b_format(7, 2, 5, 8), 'hAC, 0, 0, 'h0, 0);
        add_row(b_format(7, 5, 2, 8), 'hB4, 0, 0, 'h0, 0);
        add_row(s_format(2, 0, 1, 'h100), 'hB8, 0, 0, 'h0, 0);                 // sw
        add_row(s_format(0, 0, 2, 'h101), 'hBC, 0, 0, 'h0, 0);                 // sb
        add_row(s_format(1, 0, 12, 'h102), 'hC0, 0, 0, 'h0, 0);                // sh
        add_row(i_format('h03, 2, 20, 0, 'h100), 'hC4, 1, 20, 'hA983_FB78, 0); // lw
        add_row(i_format('h03, 0, 21, 0, 'h101), 'hC8, 1, 21, 'hFFFF_FFFB, 0); // lb
        add_row(i_format('h03, 4, 22, 0, 'h101), 'hCC, 1, 22, 'h0000_00FB, 0); // lbu
        add_row(i_format('h03, 1, 23, 0, 'h102), 'hD0, 1, 23, 'hFFFF_A983, 0); // lh
        add_row(i_format('h03, 5, 24, 0, 'h102), 'hD4, 1, 24, 'h0000_A983, 0); // lhu
        add_row(i_format('h03, 1, 25, 0, 'h100), 'hD8, 1, 25, 'hFFFF_FB78, 0);
        add_row(i_format('h13, 0, 10, 0, 42), 'hDC, 1, 10, 'h0000_002A, 0);
        add_row(i_format('h73, 0, 0, 0, 1), 'hE0, 0, 0, 'h0, 0);               // ebreak
        for (int k = 0; k < 3; k++) begin
            add_row(i_format('h13, 0, 10, 0, 7), 'hE0, 0, 0, 'h0, 1);          // Held.
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        rst   = 1'b1;
        instr = 32'h0010_0093;                         // addi x1, x0, 1.
        load_program();
        row_count = rows.size();
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_value("wb_en", 32'h0, 32'(wb_en));
        @(posedge clk);
        rst   <= 1'b0;                                 // Fourth edge still sees reset.
        instr <= rows[0].instr;
        for (int i = 0; i < row_count; i++) begin
            if (i != 0) begin
                @(posedge clk);
                instr <= rows[i].instr;
            end
            @(negedge clk);
            check_value("pc", rows[i].pc, pc);
            check_value("wb_en", 32'(rows[i].en), 32'(wb_en));
            if (rows[i].en) begin
                check_value("wb_addr", 32'(rows[i].rd), 32'(wb_addr));
                check_value("wb_data", rows[i].data, wb_data);
                if (rows[i].rd == 5'd10) begin
                    last_a0 = rows[i].data;
                end
            end
            check_value("halt", 32'(rows[i].halted), 32'(halt));
        end
        check_value("halt_code", last_a0, halt_code);
        $display("Checks done with %0d error(s)", errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Reset cycles plus table rows plus margin.
    initial begin
        wait (row_count > 0);
        #((row_count + 24) * 100);
        $display("Watchdog expired before the program table was finished");
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
rtl/rv_pkg.sv
rtl/rv_alu.sv
rtl/rv_decoder.sv
rtl/rv_exu.sv
rtl/rv_gpr.sv
rtl/rv_lsu.sv
rtl/rv_core.sv
tb/rv_core_checker.sv
tb/rv_core_tb.sv

// File: run.sh
#!/bin/sh
# Build the core testbench with Verilator, run it and judge sim.log.
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module rv_core_tb -f vlog.f -o rv_core_sim \
    && ./obj_dir/rv_core_sim 2>&1 | tee sim.log
grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log || exit 1
exit 0
